//--- design/ddr3_app_pkg.sv
// memory-side widths shared by the write path toward the DDR3 controller
package ddr3_app_pkg;

    // controller application address, column bits included
    localparam int app_addr_width = 26;

    // burst address, one step per single-beat burst
    localparam int burst_addr_width = 23;

    // zero bits appended below a burst address to form app_addr
    localparam int col_offset_bits = 3;

    // per-record countdowns and the total burst count of a fill
    localparam int burst_count_width = 24;

    // credit counter between accepted data and accepted addresses
    // five bits give headroom for a long address stall
    localparam int throttle_width = 5;

endpackage

//--- design/fill_record_pkg.sv
// layout of the tagged 132-bit records coming out of the ADC FIFO
package fill_record_pkg;

    // one FIFO record word
    localparam int record_width = 132;

    // tag sits in the top four bits of every record word
    localparam int tag_width = 4;

    // known tag codes
    localparam logic [tag_width-1:0] tag_fill_header = 4'd1;
    localparam logic [tag_width-1:0] tag_waveform_header = 4'd2;
    localparam logic [tag_width-1:0] tag_checksum = 4'd4;

    // record word with the tag stripped off
    localparam int payload_width = 128;

    // start address field of the fill header, bits 53 to 75
    localparam int start_addr_lsb = 53;

    // burst count of a waveform header, bits 0 to 22
    localparam int burst_field_width = 23;

    // fill summary written to the header FIFO
    // total burst count (24 bits) above the 128-bit payload
    localparam int summary_width = 152;

endpackage

//--- design/record_sequencer.sv
`timescale 1ns/1ps

module record_sequencer import fill_record_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 acq_enabled,
    input  logic                 acq_done,
    input  logic                 fifo_empty,
    input  logic [tag_width-1:0] fifo_tag,
    input  logic                 record_complete,
    output logic                 start_fill,
    output logic                 start_waveform,
    output logic                 start_checksum,
    output logic                 writing,
    output logic                 summary_wr_en,
    output logic                 sync_err,
    output logic                 done
);

    // one-hot fill states
    typedef enum logic [9:0] {
        st_idle       = 10'b00_0000_0001,
        st_tag_test   = 10'b00_0000_0010,
        st_sync_err   = 10'b00_0000_0100,
        st_init_fill  = 10'b00_0000_1000,
        st_init_wfm   = 10'b00_0001_0000,
        st_init_cksm  = 10'b00_0010_0000,
        st_write      = 10'b00_0100_0000,
        st_write_cksm = 10'b00_1000_0000,
        st_summary    = 10'b01_0000_0000,
        st_done       = 10'b10_0000_0000
    } fill_state_t;

    fill_state_t state;
    fill_state_t next_state;

    logic acq_done_meta;
    logic acq_done_sync;

    // acq_done comes from the acquisition side, two flops before use
    always_ff @(posedge clk) begin
        if (reset) begin
            acq_done_meta <= 1'b0;
            acq_done_sync <= 1'b0;
        end else begin
            acq_done_meta <= acq_done;
            acq_done_sync <= acq_done_meta;
        end
    end

    // dropping acq_enabled abandons the fill and clears a sync error
    always_ff @(posedge clk) begin
        if (reset || !acq_enabled) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            // FIFO is first-word fall-through, non-empty means the head is valid
            st_idle: begin
                if (!fifo_empty) begin
                    next_state = st_tag_test;
                end
            end
            st_tag_test: begin
                if (fifo_tag == tag_fill_header) begin
                    next_state = st_init_fill;
                end else if (fifo_tag == tag_waveform_header) begin
                    next_state = st_init_wfm;
                end else if (fifo_tag == tag_checksum) begin
                    next_state = st_init_cksm;
                end else begin
                    // lost record framing, park here
                    next_state = st_sync_err;
                end
            end
            st_sync_err: next_state = st_sync_err;
            st_init_fill: next_state = st_write;
            st_init_wfm: next_state = st_write;
            st_init_cksm: next_state = st_write_cksm;
            // header or waveform record, back to idle for the next tag
            st_write: begin
                if (record_complete) begin
                    next_state = st_idle;
                end
            end
            // checksum is the last record of a fill
            st_write_cksm: begin
                if (record_complete) begin
                    next_state = st_summary;
                end
            end
            st_summary: next_state = st_done;
            // hold done until the acquisition side finishes
            st_done: begin
                if (acq_done_sync) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    // init states double as the one-cycle start pulses
    assign start_fill = (state == st_init_fill);
    assign start_waveform = (state == st_init_wfm);
    assign start_checksum = (state == st_init_cksm);

    assign writing = (state == st_write) || (state == st_write_cksm);
    assign summary_wr_en = (state == st_summary);
    assign sync_err = (state == st_sync_err);
    assign done = (state == st_done);

    a_state_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot(state));

    // start pulses drive separate countdown loads in burst_tracker
    a_start_exclusive: assert property (@(posedge clk) disable iff (reset)
        $onehot0({start_fill, start_waveform, start_checksum}));

endmodule

//--- design/burst_tracker.sv
`timescale 1ns/1ps

module burst_tracker import ddr3_app_pkg::*, fill_record_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start_fill,
    input  logic                         start_waveform,
    input  logic                         start_checksum,
    input  logic                         writing,
    input  logic [burst_field_width-1:0] burst_field,
    input  logic                         fifo_empty,
    input  logic                         app_wdf_rdy,
    input  logic                         wr_app_rdy,
    output logic                         app_wdf_wren,
    output logic                         app_wdf_end,
    output logic                         wr_app_en,
    output logic                         fifo_rd_en,
    output logic                         addr_accept,
    output logic                         record_complete
);

    // words and addresses still owed for the current record
    logic [burst_count_width-1:0] data_left;
    logic [burst_count_width-1:0] addr_left;
    // data words accepted but not yet matched by an address
    logic [throttle_width-1:0]    credit;
    logic                         data_accept;

    assign data_accept = app_wdf_wren && app_wdf_rdy;
    assign addr_accept = wr_app_en && wr_app_rdy;

    // fill header and checksum are one word, a waveform is its header plus the data
    always_ff @(posedge clk) begin
        if (reset) begin
            data_left <= '0;
            addr_left <= '0;
        end else if (start_fill || start_checksum) begin
            data_left <= burst_count_width'(1);
            addr_left <= burst_count_width'(1);
        end else if (start_waveform) begin
            data_left <= burst_count_width'(burst_field) + burst_count_width'(1);
            addr_left <= burst_count_width'(burst_field) + burst_count_width'(1);
        end else begin
            if (data_accept) begin
                data_left <= data_left - burst_count_width'(1);
            end
            if (addr_accept) begin
                addr_left <= addr_left - burst_count_width'(1);
            end
        end
    end

    // throttle, an address only goes out once its data has been taken
    always_ff @(posedge clk) begin
        if (reset) begin
            credit <= '0;
        end else if (data_accept && !addr_accept) begin
            credit <= credit + throttle_width'(1);
        end else if (addr_accept && !data_accept) begin
            credit <= credit - throttle_width'(1);
        end
    end

    // single-beat bursts, end marks every data word
    assign app_wdf_wren = writing && !fifo_empty && (data_left != '0);
    assign app_wdf_end = app_wdf_wren;
    // pop the head exactly when the controller takes it
    assign fifo_rd_en = data_accept;

    assign wr_app_en = writing && (credit != '0) && (addr_left != '0);

    assign record_complete = (data_left == '0) && (addr_left == '0);

    // credit only leaves zero upward, through a data acceptance
    a_credit_no_underflow: assert property (@(posedge clk) disable iff (reset)
        (credit != '0) && ($past(credit) == '0) |-> $past(data_accept));

    // both countdowns load together, so addresses can never be ahead of data
    a_addr_behind_data: assert property (@(posedge clk) disable iff (reset)
        addr_left >= data_left);

endmodule

//--- design/fill_summary.sv
`timescale 1ns/1ps

module fill_summary import ddr3_app_pkg::*, fill_record_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start_fill,
    input  logic                        addr_accept,
    input  logic                        summary_wr_en,
    input  logic [record_width-1:0]     fifo_word,
    input  logic [burst_addr_width-1:0] fixed_start_addr,
    input  logic                        use_fixed_start,
    output logic [app_addr_width-1:0]   ddr3_wr_addr,
    output logic [summary_width-1:0]    summary
);

    logic [burst_addr_width-1:0]  burst_addr;
    logic [burst_count_width-1:0] total_count;
    logic [burst_count_width-1:0] summary_total;
    logic [payload_width-1:0]     payload_q;

    // fill header payload, tag dropped
    always_ff @(posedge clk) begin
        if (start_fill) begin
            payload_q <= fifo_word[payload_width-1:0];
        end
    end

    // burst address, start from the header field unless a fixed start is forced
    always_ff @(posedge clk) begin
        if (reset) begin
            burst_addr <= '0;
        end else if (start_fill) begin
            if (use_fixed_start) begin
                burst_addr <= fixed_start_addr;
            end else begin
                burst_addr <= fifo_word[start_addr_lsb +: burst_addr_width];
            end
        end else if (addr_accept) begin
            burst_addr <= burst_addr + burst_addr_width'(1);
        end
    end

    // counts every accepted address, fill header through checksum
    always_ff @(posedge clk) begin
        if (reset || start_fill) begin
            total_count <= '0;
        end else if (addr_accept) begin
            total_count <= total_count + burst_count_width'(1);
        end
    end

    // keep the written total so the summary stays put after the header write
    always_ff @(posedge clk) begin
        if (reset) begin
            summary_total <= '0;
        end else if (summary_wr_en) begin
            summary_total <= total_count;
        end
    end

    // column bits below the burst address are always zero
    assign ddr3_wr_addr = {burst_addr, col_offset_bits'(0)};

    // during the write cycle the live total goes straight through
    assign summary = {summary_wr_en ? total_count : summary_total, payload_q};

endmodule

//--- design/ddr3_wr_control.sv
`timescale 1ns/1ps

module ddr3_wr_control import ddr3_app_pkg::*, fill_record_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        acq_enabled,
    input  logic                        acq_done,
    // ADC FIFO, first-word fall-through
    input  logic [record_width-1:0]     ddr3_wr_fifo_dat,
    input  logic                        ddr3_wr_fifo_empty,
    output logic                        ddr3_wr_fifo_rd_en,
    // controller write data channel
    output logic                        app_wdf_wren,
    input  logic                        app_wdf_rdy,
    output logic                        app_wdf_end,
    // controller address channel
    output logic [app_addr_width-1:0]   ddr3_wr_addr,
    output logic                        wr_app_en,
    input  logic                        wr_app_rdy,
    input  logic [burst_addr_width-1:0] fixed_ddr3_start_addr,
    input  logic                        en_fixed_ddr3_start_addr,
    // header FIFO
    output logic [summary_width-1:0]    fill_header_wr_dat,
    output logic                        fill_header_wr_en,
    // status
    output logic                        ddr3_wr_sync_err,
    output logic                        ddr3_wr_done
);

    logic start_fill;
    logic start_waveform;
    logic start_checksum;
    logic writing;
    logic record_complete;
    logic addr_accept;

    record_sequencer u_record_sequencer (
        .clk             (clk),
        .reset           (reset),
        .acq_enabled     (acq_enabled),
        .acq_done        (acq_done),
        .fifo_empty      (ddr3_wr_fifo_empty),
        .fifo_tag        (ddr3_wr_fifo_dat[record_width-1 -: tag_width]),
        .record_complete (record_complete),
        .start_fill      (start_fill),
        .start_waveform  (start_waveform),
        .start_checksum  (start_checksum),
        .writing         (writing),
        .summary_wr_en   (fill_header_wr_en),
        .sync_err        (ddr3_wr_sync_err),
        .done            (ddr3_wr_done)
    );

    // burst count lives in the low bits of a waveform header
    burst_tracker u_burst_tracker (
        .clk             (clk),
        .reset           (reset),
        .start_fill      (start_fill),
        .start_waveform  (start_waveform),
        .start_checksum  (start_checksum),
        .writing         (writing),
        .burst_field     (ddr3_wr_fifo_dat[burst_field_width-1:0]),
        .fifo_empty      (ddr3_wr_fifo_empty),
        .app_wdf_rdy     (app_wdf_rdy),
        .wr_app_rdy      (wr_app_rdy),
        .app_wdf_wren    (app_wdf_wren),
        .app_wdf_end     (app_wdf_end),
        .wr_app_en       (wr_app_en),
        .fifo_rd_en      (ddr3_wr_fifo_rd_en),
        .addr_accept     (addr_accept),
        .record_complete (record_complete)
    );

    fill_summary u_fill_summary (
        .clk              (clk),
        .reset            (reset),
        .start_fill       (start_fill),
        .addr_accept      (addr_accept),
        .summary_wr_en    (fill_header_wr_en),
        .fifo_word        (ddr3_wr_fifo_dat),
        .fixed_start_addr (fixed_ddr3_start_addr),
        .use_fixed_start  (en_fixed_ddr3_start_addr),
        .ddr3_wr_addr     (ddr3_wr_addr),
        .summary          (fill_header_wr_dat)
    );

endmodule

//--- verification/ddr3_wr_control_tb.sv
`timescale 1ns/1ps

module ddr3_wr_control_tb;

    localparam int rec_w = 132;
    localparam int sum_w = 152;
    localparam int payload_w = 128;
    localparam logic [3:0] tag_wfm = 4'h2;
    localparam int start_lsb = 53;
    localparam int done_timeout = 2000;
    localparam int short_timeout = 20;

    logic clk = 1'b0;
    logic reset;
    logic acq_enabled;
    logic acq_done;
    logic [rec_w-1:0] ddr3_wr_fifo_dat;
    logic ddr3_wr_fifo_empty;
    logic ddr3_wr_fifo_rd_en;
    logic app_wdf_wren;
    logic app_wdf_rdy;
    logic app_wdf_end;
    logic [25:0] ddr3_wr_addr;
    logic wr_app_en;
    logic wr_app_rdy;
    logic [22:0] fixed_ddr3_start_addr;
    logic en_fixed_ddr3_start_addr;
    logic [sum_w-1:0] fill_header_wr_dat;
    logic fill_header_wr_en;
    logic ddr3_wr_sync_err;
    logic ddr3_wr_done;

    // FIFO contents, and the words the current fill must deliver in order
    logic [rec_w-1:0] fifo_q[$];
    logic [rec_w-1:0] exp_words[$];
    logic [22:0] exp_start;
    logic pop_pending = 1'b0;
    logic quiet = 1'b0;
    logic prev_stall = 1'b0;
    int data_cnt = 0;
    int addr_cnt = 0;
    int hdr_cnt = 0;
    int data_errors = 0;
    int addr_errors = 0;
    int summary_errors = 0;
    int status_errors = 0;
    int timeout_errors = 0;

    ddr3_wr_control u_ddr3_wr_control (.*);

    always #20 clk = ~clk;

    // FIFO head and both ready signals move on the falling edge only
    initial begin
        int seed_val;
        seed_val = $urandom(32'h7585c215);
        app_wdf_rdy = 1'b0;
        wr_app_rdy = 1'b0;
        ddr3_wr_fifo_dat = '0;
        ddr3_wr_fifo_empty = 1'b1;
        forever begin
            @(negedge clk);
            if (pop_pending && fifo_q.size() > 0) begin
                fifo_q.delete(0);
            end
            pop_pending = 1'b0;
            ddr3_wr_fifo_empty = (fifo_q.size() == 0);
            ddr3_wr_fifo_dat = (fifo_q.size() > 0) ? fifo_q[0] : '0;
            // address side is faster on average so credit stays small
            app_wdf_rdy = ($urandom % 2) != 0;
            wr_app_rdy = ($urandom % 4) != 0;
        end
    end

    // acceptances happen at the rising edge with inputs settled since the falling one
    always @(posedge clk) begin
        if (!reset) begin
            if (ddr3_wr_fifo_rd_en !== (app_wdf_wren && app_wdf_rdy)) begin
                data_errors++;
                $display("Fail %0t: fifo_rd_en does not match data acceptance", $time);
            end
            if (app_wdf_end !== app_wdf_wren) begin
                data_errors++;
                $display("Fail %0t: app_wdf_end differs from app_wdf_wren", $time);
            end
            // a stalled word has to stay offered
            if (prev_stall && !app_wdf_wren) begin
                data_errors++;
                $display("Fail %0t: write data withdrawn under back-pressure", $time);
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                if (data_cnt >= exp_words.size()) begin
                    data_errors++;
                    $display("Fail %0t: extra data word accepted", $time);
                end else if (ddr3_wr_fifo_dat !== exp_words[data_cnt]) begin
                    data_errors++;
                    $display("Fail %0t: data word %0d is %h, expected %h", $time, data_cnt,
                        ddr3_wr_fifo_dat, exp_words[data_cnt]);
                end
                data_cnt++;
                pop_pending = 1'b1;
            end
            if (wr_app_en && wr_app_rdy) begin
                if (ddr3_wr_addr !== {exp_start + addr_cnt[22:0], 3'b000}) begin
                    addr_errors++;
                    $display("Fail %0t: address %0d is %h, expected %h", $time, addr_cnt,
                        ddr3_wr_addr, {exp_start + addr_cnt[22:0], 3'b000});
                end
                addr_cnt++;
                if (addr_cnt > data_cnt) begin
                    addr_errors++;
                    $display("Fail %0t: %0d addresses ahead of %0d data words", $time,
                        addr_cnt, data_cnt);
                end
            end
            if (quiet && (app_wdf_wren || wr_app_en)) begin
                status_errors++;
                $display("Fail %0t: memory write offered after a bad tag", $time);
            end
            if (fill_header_wr_en) begin
                hdr_cnt++;
                if (ddr3_wr_done) begin
                    status_errors++;
                    $display("Fail %0t: done already high at the summary write", $time);
                end
                if (fill_header_wr_dat[payload_w-1:0] !== exp_words[0][payload_w-1:0]) begin
                    summary_errors++;
                    $display("Fail %0t: summary payload is %h", $time,
                        fill_header_wr_dat[payload_w-1:0]);
                end
                if (fill_header_wr_dat[sum_w-1:payload_w] !== addr_cnt[23:0]) begin
                    summary_errors++;
                    $display("Fail %0t: summary total %0d, expected %0d", $time,
                        fill_header_wr_dat[sum_w-1:payload_w], addr_cnt);
                end
            end
            prev_stall = app_wdf_wren && !app_wdf_rdy;
        end
    end

    task automatic check_reset_outputs;
        if (app_wdf_wren || wr_app_en || ddr3_wr_fifo_rd_en || fill_header_wr_en
            || ddr3_wr_sync_err || ddr3_wr_done) begin
            status_errors++;
            $display("Fail %0t: outputs not all low during reset", $time);
        end
    endtask

    // one fill from the listed words with done released through acq_done
    task automatic run_fill(input int file_total);
        int exp_total;
        int len;
        int k;
        int n;
        exp_total = 0;
        k = 0;
        // fill header and checksum are one word, a waveform is its count plus one
        while (k < exp_words.size()) begin
            if (exp_words[k][rec_w-1 -: 4] == tag_wfm) begin
                len = int'(exp_words[k][22:0]) + 1;
            end else begin
                len = 1;
            end
            exp_total += len;
            k += len;
        end
        if (exp_total != file_total) begin
            status_errors++;
            $display("stimulus total %0d does not match the record lengths (%0d)",
                file_total, exp_total);
        end
        exp_start = en_fixed_ddr3_start_addr ? fixed_ddr3_start_addr
                                             : exp_words[0][start_lsb +: 23];
        data_cnt = 0;
        addr_cnt = 0;
        hdr_cnt = 0;
        @(posedge clk);
        foreach (exp_words[i]) begin
            fifo_q.push_back(exp_words[i]);
        end
        for (n = 0; n < done_timeout && !ddr3_wr_done; n++) begin
            @(negedge clk);
        end
        if (!ddr3_wr_done) begin
            timeout_errors++;
            $display("timed out after %0d cycles waiting for done", done_timeout);
        end else begin
            // done holds while acq_done stays low
            repeat (4) begin
                @(negedge clk);
                if (!ddr3_wr_done) begin
                    status_errors++;
                    $display("Fail %0t: done dropped while acq_done was low", $time);
                end
            end
        end
        if (hdr_cnt != 1) begin
            summary_errors++;
            $display("Fail %0t: header FIFO written %0d times", $time, hdr_cnt);
        end
        if (data_cnt != exp_total || addr_cnt != exp_total) begin
            addr_errors++;
            $display("Fail %0t: %0d data words and %0d addresses, expected %0d", $time,
                data_cnt, addr_cnt, exp_total);
        end
        acq_done = 1'b1;
        for (n = 0; n < short_timeout && ddr3_wr_done; n++) begin
            @(negedge clk);
        end
        if (ddr3_wr_done) begin
            timeout_errors++;
            $display("done did not fall after acq_done was applied");
        end else if (n < 2 || n > 3) begin
            status_errors++;
            $display("Fail %0t: done fell %0d cycles after acq_done, expected 2 or 3",
                $time, n);
        end
        acq_done = 1'b0;
        exp_words.delete();
    endtask

    task automatic run_bad_tag(input logic [rec_w-1:0] word);
        int n;
        quiet = 1'b1;
        @(posedge clk);
        fifo_q.push_back(word);
        for (n = 0; n < short_timeout && !ddr3_wr_sync_err; n++) begin
            @(negedge clk);
        end
        if (!ddr3_wr_sync_err) begin
            timeout_errors++;
            $display("sync_err never rose for an unknown tag");
        end
        // parked in the error state with no memory traffic
        repeat (5) @(negedge clk);
        if (!ddr3_wr_sync_err) begin
            status_errors++;
            $display("Fail %0t: sync_err did not hold", $time);
        end
        acq_enabled = 1'b0;
        for (n = 0; n < short_timeout && ddr3_wr_sync_err; n++) begin
            @(negedge clk);
        end
        if (ddr3_wr_sync_err) begin
            timeout_errors++;
            $display("sync_err stuck after acq_enabled went low");
        end
        // flush the bad record before the machine is enabled again
        @(posedge clk);
        fifo_q.delete();
        @(negedge clk);
        acq_enabled = 1'b1;
        quiet = 1'b0;
    endtask

    initial begin
        int fd;
        int code;
        logic [63:0] cmd;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [payload_w-1:0] payload;
        logic [8*256-1:0] rest;
        reset = 1'b1;
        acq_enabled = 1'b0;
        acq_done = 1'b0;
        fixed_ddr3_start_addr = '0;
        en_fixed_ddr3_start_addr = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_reset_outputs();
        reset = 1'b0;
        acq_enabled = 1'b1;
        fd = $fopen("verification/wr_stimulus.txt", "r");
        if (fd == 0) begin
            status_errors++;
            $display("could not open the stimulus file");
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd == "#") begin
                    code = $fgets(rest, fd);
                end else if (cmd == "cfg") begin
                    code = $fscanf(fd, "%h %h", arg_a, arg_b);
                    @(negedge clk);
                    en_fixed_ddr3_start_addr = arg_a[0];
                    fixed_ddr3_start_addr = arg_b[22:0];
                end else if (cmd == "word") begin
                    code = $fscanf(fd, "%h %h", arg_a, payload);
                    exp_words.push_back({arg_a[3:0], payload});
                end else if (cmd == "expect") begin
                    code = $fscanf(fd, "%h", arg_a);
                    run_fill(int'(arg_a));
                end else if (cmd == "badtag") begin
                    code = $fscanf(fd, "%h %h", arg_a, payload);
                    run_bad_tag({arg_a[3:0], payload});
                end else begin
                    status_errors++;
                    $display("unknown line kind in the stimulus file");
                end
            end
            $fclose(fd);
        end
        $display("errors: data %0d, address %0d, summary %0d, status %0d, timeout %0d",
            data_errors, addr_errors, summary_errors, status_errors, timeout_errors);
        if (data_errors + addr_errors + summary_errors + status_errors + timeout_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verification/wr_stimulus.txt
# word <tag> <payload>, both hex, 128-bit payload right aligned
# cfg <fixed start enable> <fixed start burst address>, expect <total bursts, hex>, badtag <tag> <payload>
cfg 0 0
word 1 deadbeef0000002468a0000000abcdef
word 2 cafe0000000000000000000000000003
word 3 11111111111111111111111111111111
word 5 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
word 0 0123456789abcdef0123456789abcdef
word 2 0
word 4 feedface
expect 7
cfg 1 7abcde
word 1 0123456789abcdef0123456789abcdef
word 2 5
word a 1
word a 2
word a 3
word a 4
word a 5
word 4 9
expect 8
badtag f 0bad

//--- tb.f
design/ddr3_app_pkg.sv
design/fill_record_pkg.sv
design/record_sequencer.sv
design/burst_tracker.sv
design/fill_summary.sv
design/ddr3_wr_control.sv
verification/ddr3_wr_control_tb.sv

//--- Bender.yml
package:
  name: ddr3_wr_control

sources:
  - design/ddr3_app_pkg.sv
  - design/fill_record_pkg.sv
  - design/record_sequencer.sv
  - design/burst_tracker.sv
  - design/fill_summary.sv
  - design/ddr3_wr_control.sv
  - target: test
    files:
      - verification/ddr3_wr_control_tb.sv
